/* Makefile */
.PHONY: help test clean

help:
	@echo "make test   build frontend_tb with Verilator, run it and check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module frontend_tb \
	  -f frontend_top.f -Mdir obj_dir -o frontend_sim
	./obj_dir/frontend_sim | tee sim.log
	grep -qx "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

/* decode.sv */
`timescale 1ns/100ps

module decode
  import frontend_pkg::*;
(
  input  word_t    inst,
  output decoded_t dec
);

  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;

  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_u;
  word_t imm_j;

  // bit 31 is the sign bit in every format
  assign imm_i = {{21{inst[31]}}, inst[30:20]};
  assign imm_s = {{21{inst[31]}}, inst[30:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec.funct3 = inst[14:12];
    dec.funct7 = inst[31:25];
    dec.opcode = inst[6:0];
    dec.rs1_s  = inst[19:15];
    dec.rs2_s  = inst[24:20];
    dec.rd_s   = inst[11:7];

    // register-register ops and anything unknown carry no immediate
    case (inst[6:0])
      OP_JALR, OP_LOAD, OP_IMM: dec.imm = imm_i;
      OP_STORE:                 dec.imm = imm_s;
      OP_BRANCH:                dec.imm = imm_b;
      OP_LUI, OP_AUIPC:         dec.imm = imm_u;
      OP_JAL:                   dec.imm = imm_j;
      default:                  dec.imm = '0;
    endcase
  end

endmodule

/* fetch_ctrl.sv */
`timescale 1ns/100ps
`include "frontend_defines.svh"

module fetch_ctrl
  import frontend_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   move_flush,
  input  word_t  redirect_pc,
  input  logic   instr_full,
  input  logic   imem_resp,
  output logic   imem_req,
  output word_t  imem_addr,
  output logic   move_fetch,
  output word_t  fetch_pc,
  output order_t fetch_order,
  output logic   iq_resp
);

  localparam int CNT_W = $clog2(`FRONTEND_MAX_OUTSTANDING + 1);
  localparam logic [CNT_W-1:0] MAX_OPEN = CNT_W'(`FRONTEND_MAX_OUTSTANDING);

  word_t            pc_q;
  order_t           order_q;
  logic [CNT_W-1:0] open_cnt;
  logic [CNT_W-1:0] drop_cnt;
  logic             req;
  logic             dropping;

  // responses still owed to requests made before the last flush
  assign dropping = (drop_cnt != '0);

  // a reset or a flush holds fetch for the cycle it is present
  assign req = !rst && !move_flush && !instr_full && (open_cnt < MAX_OPEN);

  assign imem_req    = req;
  assign move_fetch  = req;
  assign imem_addr   = pc_q;
  assign fetch_pc    = pc_q;
  assign fetch_order = order_q;

  // a word that answers a request from before the flush never reaches the queue
  assign iq_resp = imem_resp && !dropping && !move_flush;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q     <= `FRONTEND_RESET_PC;
      order_q  <= '0;
      open_cnt <= '0;
      drop_cnt <= '0;
    end else begin
      open_cnt <= open_cnt + CNT_W'(req) - CNT_W'(imem_resp);
      if (req) begin
        pc_q    <= pc_q + 32'd4;
        order_q <= order_q + 64'd1;
      end
      if (move_flush) begin
        pc_q <= redirect_pc;
        // every request open at the flush is stale, the one answered now included
        drop_cnt <= open_cnt - CNT_W'(imem_resp);
      end else if (imem_resp && dropping) begin
        drop_cnt <= drop_cnt - 1'b1;
      end
    end
  end

  open_limit_a: assert property (@(posedge clk) disable iff (rst)
    open_cnt <= MAX_OPEN);

  // the memory answers only what was asked
  no_stray_resp_a: assert property (@(posedge clk) disable iff (rst)
    imem_resp |-> (open_cnt != '0));

endmodule

/* frontend_checker.sv */
`timescale 1ns/100ps
`include "frontend_defines.svh"

module frontend_checker
  import frontend_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   move_flush,
  input  word_t  redirect_pc,
  input  logic   instr_ready,
  input  logic   instr_pop,
  input  issue_t issue,
  input  word_t  pc_word,
  output word_t  expected_pc,
  output int     error_count,
  output int     pop_count
);

  int       errors = 0;
  int       pops = 0;
  word_t    exp_pc;
  order_t   last_order;
  logic     order_known;
  logic     flushed;
  logic     holding;
  issue_t   held;
  decoded_t exp_dec;

  assign error_count = errors;
  assign pop_count   = pops;
  assign expected_pc = exp_pc;

  // RV32I field layout, immediate chosen by the opcode's format
  function automatic decoded_t ref_decode(input word_t w);
    decoded_t d;
    word_t    sx;
    sx       = word_t'($signed(w) >>> 20);
    d.opcode = w[6:0];
    d.rd_s   = w[11:7];
    d.funct3 = w[14:12];
    d.rs1_s  = w[19:15];
    d.rs2_s  = w[24:20];
    d.funct7 = w[31:25];
    case (w[6:0])
      7'b0000011, 7'b0010011, 7'b1100111: d.imm = sx;
      7'b0100011: d.imm = {sx[31:5], w[11:7]};
      7'b1100011: d.imm = {sx[31:12], w[7], w[30:25], w[11:8], 1'b0};
      7'b0110111, 7'b0010111: d.imm = {w[31:12], 12'h000};
      7'b1101111: d.imm = {sx[31:20], w[19:12], w[20], w[30:21], 1'b0};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic check_entry();
    exp_dec = ref_decode(issue.instr);
    if (issue.pc !== exp_pc)
      report_mismatch($sformatf("pc %h, expected %h", issue.pc, exp_pc));
    if (issue.pc_next !== exp_pc + 32'd4)
      report_mismatch($sformatf("pc_next %h, expected %h", issue.pc_next, exp_pc + 32'd4));
    if (issue.instr !== pc_word)
      report_mismatch($sformatf("word %h at pc %h, expected %h", issue.instr, issue.pc, pc_word));
    if (issue.dec !== exp_dec)
      report_mismatch($sformatf("decode of %h is %h, expected %h",
                                issue.instr, issue.dec, exp_dec));
    // after a flush the order only has to move forward
    if (flushed) begin
      if (order_known && issue.order <= last_order)
        report_mismatch($sformatf("order %0d after flush, last %0d", issue.order, last_order));
    end else if (!order_known) begin
      if (issue.order !== '0)
        report_mismatch($sformatf("first order %0d, expected 0", issue.order));
    end else if (issue.order !== last_order + 64'd1) begin
      report_mismatch($sformatf("order %0d, expected %0d", issue.order, last_order + 64'd1));
    end
    exp_pc      = exp_pc + 32'd4;
    last_order  = issue.order;
    order_known = 1'b1;
    flushed     = 1'b0;
    pops++;
  endtask

  // inputs change just after the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin
    if (rst) begin
      exp_pc      = `FRONTEND_RESET_PC;
      order_known = 1'b0;
      flushed     = 1'b0;
      holding     = 1'b0;
    end else begin
      if (holding && !instr_ready)
        report_mismatch("instr_ready dropped while nothing was popped");
      else if (holding && issue !== held)
        report_mismatch("issued entry changed while nothing was popped");
      holding = instr_ready && !instr_pop && !move_flush;
      held    = issue;
      if (move_flush) begin
        exp_pc  = redirect_pc;
        flushed = 1'b1;
      end else if (instr_pop) begin
        check_entry();
      end
    end
  end

endmodule

/* frontend_defines.svh */
`ifndef FRONTEND_DEFINES_SVH
`define FRONTEND_DEFINES_SVH

// the instruction queue holds 2**FRONTEND_IQ_DEPTH_BITS entries
`define FRONTEND_IQ_DEPTH_BITS 3

// first address fetched after reset
`define FRONTEND_RESET_PC 32'h0000_1000

// requests that may be waiting for a memory response at any one time
`define FRONTEND_MAX_OUTSTANDING 8

`endif

/* frontend_pkg.sv */
package frontend_pkg;

  // PCs, instruction words and immediates all share this width
  typedef logic [31:0] word_t;

  // fetch sequence number, it only ever counts up
  typedef logic [63:0] order_t;

  // architectural register specifier
  typedef logic [4:0] reg_idx_t;

  // major opcode in bits 6:0 of an instruction
  typedef logic [6:0] opcode_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [6:0] funct7;
    opcode_t    opcode;
    word_t      imm;
    reg_idx_t   rs1_s;
    reg_idx_t   rs2_s;
    reg_idx_t   rd_s;
  } decoded_t;

  // everything the issue stage needs about one fetched instruction
  typedef struct packed {
    order_t   order;
    word_t    pc;
    word_t    pc_next;
    word_t    instr;
    decoded_t dec;
  } issue_t;

endpackage

/* frontend_tb.sv */
`timescale 1ns/100ps

module frontend_tb
  import frontend_pkg::*;
();

  logic   clk;
  logic   rst;
  logic   move_flush;
  word_t  redirect_pc;
  logic   imem_req;
  word_t  imem_addr;
  logic   imem_resp;
  word_t  imem_rdata;
  logic   instr_ready;
  logic   instr_pop;
  issue_t issue;
  word_t  pc_word;
  word_t  expected_pc;
  int     check_errors;
  int     pop_count;
  int     run_errors;
  int     seed = 32'h31e957d7;
  int     mem_cycle;
  word_t  pend_addr[$];
  int     pend_due[$];

  // instruction memory contents, a hash of the whole address picks the format
  function automatic word_t mem_word(input word_t addr);
    word_t      h;
    logic [6:0] op;
    h = addr * 32'h9e37_79b1;
    h = h ^ (h >> 13) ^ (addr << 7);
    case (h[2:0])
      3'd0: op = 7'b0110111;
      3'd1: op = 7'b0010111;
      3'd2: op = 7'b1101111;
      3'd3: op = 7'b1100111;
      3'd4: op = 7'b1100011;
      3'd5: op = 7'b0000011;
      3'd6: op = 7'b0100011;
      default: op = h[3] ? 7'b0010011 : (h[4] ? 7'b0110011 : 7'b1111111);
    endcase
    return {h[31:7], op};
  endfunction

  function automatic int roll_percent();
    return {$random(seed)} % 100;
  endfunction

  frontend_top dut_i (
    .clk         (clk),
    .rst         (rst),
    .move_flush  (move_flush),
    .redirect_pc (redirect_pc),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .imem_resp   (imem_resp),
    .imem_rdata  (imem_rdata),
    .instr_ready (instr_ready),
    .instr_pop   (instr_pop),
    .issue       (issue)
  );

  frontend_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .move_flush  (move_flush),
    .redirect_pc (redirect_pc),
    .instr_ready (instr_ready),
    .instr_pop   (instr_pop),
    .issue       (issue),
    .pc_word     (pc_word),
    .expected_pc (expected_pc),
    .error_count (check_errors),
    .pop_count   (pop_count)
  );

  assign pc_word = mem_word(expected_pc);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // memory answers in request order, each word 1 to 4 cycles after its request
  initial begin
    imem_resp  = 1'b0;
    imem_rdata = '0;
    mem_cycle  = 0;
    forever begin
      @(negedge clk);
      if (!rst && imem_req) begin
        pend_addr.push_back(imem_addr);
        pend_due.push_back(mem_cycle + 1 + int'({$random(seed)} % 4));
      end
      @(posedge clk);
      mem_cycle = mem_cycle + 1;
      #2;
      imem_resp = 1'b0;
      if (pend_addr.size() != 0 && pend_due[0] <= mem_cycle) begin
        imem_resp  = 1'b1;
        imem_rdata = mem_word(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
    end
  end

  task automatic run_cycles(input int cycles, input int pop_pct, input int flush_pct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      #2;
      move_flush = 1'b0;
      instr_pop  = 1'b0;
      if (flush_pct != 0 && roll_percent() < flush_pct) begin
        move_flush  = 1'b1;
        redirect_pc = word_t'($random(seed)) & 32'hffff_fffc;
      end else if (instr_ready && roll_percent() < pop_pct) begin
        instr_pop = 1'b1;
      end
    end
  endtask

  task automatic flush_and_wait(input int limit);
    int waited;
    waited = 0;
    run_cycles(1, 0, 100);
    run_cycles(1, 0, 0);
    while (!instr_ready && waited < limit) begin
      run_cycles(1, 0, 0);
      waited++;
    end
    if (!instr_ready) begin
      $display("timeout at %0t: nothing became ready within %0d cycles of a flush",
               $time, limit);
      run_errors++;
    end
  endtask

  initial begin
    rst         = 1'b1;
    move_flush  = 1'b0;
    redirect_pc = '0;
    instr_pop   = 1'b0;
    run_errors  = 0;
    repeat (3) @(posedge clk);
    #2;
    rst = 1'b0;
    run_cycles(300, 70, 0);
    // long stall, the queue fills and holds fetch back
    run_cycles(60, 0, 0);
    run_cycles(200, 50, 0);
    run_cycles(600, 60, 3);
    flush_and_wait(60);
    // flush again right away, while requests made after the first flush are still open
    flush_and_wait(60);
    // long stall, then a flush with a full queue
    run_cycles(50, 0, 0);
    flush_and_wait(60);
    run_cycles(200, 100, 0);
    run_cycles(2, 0, 0);
    if (pop_count < 500) begin
      $display("too few instructions were issued: %0d", pop_count);
      run_errors++;
    end
    $display("check errors %0d, other errors %0d, issued %0d",
             check_errors, run_errors, pop_count);
    if (check_errors == 0 && run_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* frontend_top.f */
+incdir+.
frontend_pkg.sv
fetch_ctrl.sv
decode.sv
instruction_queue.sv
frontend_top.sv
frontend_checker.sv
frontend_tb.sv

/* frontend_top.sv */
`timescale 1ns/100ps

module frontend_top
  import frontend_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   move_flush,
  input  word_t  redirect_pc,
  output logic   imem_req,
  output word_t  imem_addr,
  input  logic   imem_resp,
  input  word_t  imem_rdata,
  output logic   instr_ready,
  input  logic   instr_pop,
  output issue_t issue
);

  logic   move_fetch;
  word_t  fetch_pc;
  order_t fetch_order;
  logic   iq_resp;
  logic   instr_full;

  fetch_ctrl fetch_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .move_flush  (move_flush),
    .redirect_pc (redirect_pc),
    .instr_full  (instr_full),
    .imem_resp   (imem_resp),
    .imem_req    (imem_req),
    .imem_addr   (imem_addr),
    .move_fetch  (move_fetch),
    .fetch_pc    (fetch_pc),
    .fetch_order (fetch_order),
    .iq_resp     (iq_resp)
  );

  // only filtered responses reach the queue
  instruction_queue instruction_queue_i (
    .clk         (clk),
    .rst         (rst),
    .move_flush  (move_flush),
    .move_fetch  (move_fetch),
    .imem_resp   (iq_resp),
    .instr_pop   (instr_pop),
    .imem_rdata  (imem_rdata),
    .fetch_order (fetch_order),
    .fetch_pc    (fetch_pc),
    .instr_full  (instr_full),
    .instr_valid (),
    .instr_ready (instr_ready),
    .issue       (issue)
  );

endmodule

/* instruction_queue.sv */
`timescale 1ns/100ps
`include "frontend_defines.svh"

module instruction_queue
  import frontend_pkg::*;
#(
  parameter int DEPTH_BITS = `FRONTEND_IQ_DEPTH_BITS
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   move_flush,
  input  logic   move_fetch,
  input  logic   imem_resp,
  input  logic   instr_pop,
  input  word_t  imem_rdata,
  input  order_t fetch_order,
  input  word_t  fetch_pc,
  output logic   instr_full,
  output logic   instr_valid,
  output logic   instr_ready,
  output issue_t issue
);

  localparam int ENTRIES = 2 ** DEPTH_BITS;

  typedef logic [DEPTH_BITS-1:0] idx_t;

  // a slot is reserved at fetch time and completed when its word comes back
  order_t order_mem [ENTRIES];
  word_t  pc_mem    [ENTRIES];
  word_t  instr_mem [ENTRIES];

  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] ready_q;
  idx_t               valid_head;
  idx_t               valid_tail;
  idx_t               ready_head;
  idx_t               ready_tail;
  word_t              tail_instr;
  decoded_t           tail_dec;

  // the ring is full once the next slot to reserve is still occupied
  assign instr_full  = valid_q[valid_head];
  assign instr_valid = valid_q[valid_tail];
  assign instr_ready = ready_q[ready_tail];

  assign tail_instr = instr_mem[ready_tail];

  decode decode_i (
    .inst (tail_instr),
    .dec  (tail_dec)
  );

  always_comb begin
    issue.order   = order_mem[ready_tail];
    issue.pc      = pc_mem[ready_tail];
    issue.pc_next = pc_mem[ready_tail] + 32'd4;
    issue.instr   = tail_instr;
    issue.dec     = tail_dec;
  end

  always_ff @(posedge clk) begin
    if (rst || move_flush) begin
      valid_q    <= '0;
      ready_q    <= '0;
      valid_head <= '0;
      valid_tail <= '0;
      ready_head <= '0;
      ready_tail <= '0;
    end else begin
      if (instr_pop) begin
        valid_q[valid_tail] <= 1'b0;
        ready_q[ready_tail] <= 1'b0;
        valid_tail          <= valid_tail + 1'b1;
        ready_tail          <= ready_tail + 1'b1;
      end
      if (move_fetch) begin
        valid_q[valid_head] <= 1'b1;
        valid_head          <= valid_head + 1'b1;
      end
      // responses come back in request order, so they fill slots in order too
      if (imem_resp) begin
        ready_q[ready_head] <= 1'b1;
        ready_head          <= ready_head + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (move_fetch) begin
      pc_mem[valid_head]    <= fetch_pc;
      order_mem[valid_head] <= fetch_order;
    end
    if (imem_resp) begin
      instr_mem[ready_head] <= imem_rdata;
    end
  end

  // fetch has to look at instr_full before it reserves a slot
  no_push_full_a: assert property (@(posedge clk) disable iff (rst)
    move_fetch |-> !instr_full);

  no_pop_unready_a: assert property (@(posedge clk) disable iff (rst)
    instr_pop |-> instr_ready);

endmodule
